// ==== common/rp_consts.svh ====
// analog path constants
// channel count, widths, calibration scaling and limits,
// and the register map of the calibration bank
`ifndef RP_CONSTS_SVH
`define RP_CONSTS_SVH

// channels on each side
`define RP_CHN        2

// pin, sample and bus widths
`define RP_ADC_W      16
`define RP_SMP_W      14
`define RP_GAIN_W     16
`define RP_ADDR_W     4
`define RP_DATA_W     16

// gain is fixed point with 14 fraction bits
`define RP_GAIN_FRAC  14
`define RP_GAIN_UNITY 16384

// saturation limits of a 14 bit sample
`define RP_SMP_MAX    8191
`define RP_SMP_MIN    (-8192)

// register map
// per channel registers sit at base plus channel index
`define RP_A_ADC_MUL  0
`define RP_A_ADC_SUM  2
`define RP_A_DAC_MUL  4
`define RP_A_DAC_SUM  6
`define RP_A_LOOP     8

`endif

// ==== common/rp_pkg.sv ====
// analog path types
// samples, calibration words, DAC codes and the
// configuration port of the register bank
`default_nettype none

`include "rp_consts.svh"

package rp_pkg;

  //////////////////////////////
  // data path
  //////////////////////////////

  // raw ADC pins, low 2 bits unused
  typedef logic        [`RP_ADC_W-1:0]  adc_word_t;

  // signed two's complement sample
  typedef logic signed [`RP_SMP_W-1:0]  smp_t;

  // offset binary code toward the DAC
  typedef logic        [`RP_SMP_W-1:0]  dac_code_t;

  //////////////////////////////
  // calibration
  //////////////////////////////

  // gain, 1.0 == 2**RP_GAIN_FRAC
  typedef logic signed [`RP_GAIN_W-1:0] gain_t;

  // offset in sample units
  typedef logic signed [`RP_SMP_W-1:0]  offs_t;

  //////////////////////////////
  // configuration port
  //////////////////////////////

  typedef logic        [`RP_ADDR_W-1:0] cfg_addr_t;
  typedef logic        [`RP_DATA_W-1:0] cfg_data_t;

  // one bit per channel
  typedef logic        [`RP_CHN-1:0]    chn_mask_t;

endpackage

`default_nettype wire

// ==== hdl/linear_calib.sv ====
// linear calibration stage
// out = sat((smp * gain) >>> 14 + offs), two register stages
`timescale 1ns/1ps
`default_nettype none

`include "rp_consts.svh"

module linear_calib (
  input  logic          adc_clk,
  input  logic          top_rst,
  input  rp_pkg::smp_t  smp_i,
  input  rp_pkg::gain_t gain_i,
  input  rp_pkg::offs_t offs_i,
  output rp_pkg::smp_t  smp_o
);

  import rp_pkg::*;

  // full product width
  localparam int unsigned PRD_W = `RP_SMP_W + `RP_GAIN_W;
  // width after dropping the gain fraction
  localparam int unsigned SHR_W = PRD_W - `RP_GAIN_FRAC;
  // one guard bit for the offset add
  localparam int unsigned SUM_W = SHR_W + 1;

  logic signed [PRD_W-1:0] prod_q;
  offs_t                   offs_q;
  logic signed [SHR_W-1:0] prod_shr;
  logic signed [SUM_W-1:0] sum;

  //////////////////////////////
  // stage 1 multiply
  //////////////////////////////

  // offset travels along with its sample
  // so gain and offset always come from the same cycle
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      prod_q <= '0;
      offs_q <= '0;
    end else begin
      prod_q <= smp_i * gain_i;
      offs_q <= offs_i;
    end
  end

  //////////////////////////////
  // stage 2 offset and clamp
  //////////////////////////////

  // arithmetic shift by the fraction bits
  assign prod_shr = $signed(prod_q[PRD_W-1:`RP_GAIN_FRAC]);

  // both operands sign extended to the sum width
  assign sum = prod_shr + offs_q;

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      smp_o <= '0;
    end else if (sum > `RP_SMP_MAX) begin
      // positive overflow
      smp_o <= smp_t'(`RP_SMP_MAX);
    end else if (sum < `RP_SMP_MIN) begin
      // negative overflow
      smp_o <= smp_t'(`RP_SMP_MIN);
    end else begin
      smp_o <= smp_t'(sum);
    end
  end

endmodule

`default_nettype wire

// ==== hdl/calib_regs.sv ====
// calibration register bank
// ADC and DAC gains and offsets plus the loopback mask,
// written by a plain strobe, read back one cycle after the address
`timescale 1ns/1ps
`default_nettype none

`include "rp_consts.svh"

module calib_regs (
  input  logic                                  adc_clk,
  input  logic                                  top_rst,
  // configuration port
  input  logic                                  cfg_we_i,
  input  rp_pkg::cfg_addr_t                     cfg_addr_i,
  input  rp_pkg::cfg_data_t                     cfg_wdata_i,
  output rp_pkg::cfg_data_t                     cfg_rdata_o,
  // calibration toward the ADC path
  output rp_pkg::gain_t     [`RP_CHN-1:0]       adc_gain_o,
  output rp_pkg::offs_t     [`RP_CHN-1:0]       adc_offs_o,
  // calibration toward the DAC path
  output rp_pkg::gain_t     [`RP_CHN-1:0]       dac_gain_o,
  output rp_pkg::offs_t     [`RP_CHN-1:0]       dac_offs_o,
  // digital loopback per channel
  output rp_pkg::chn_mask_t                     loop_o
);

  import rp_pkg::*;

  // readback value before the output register
  cfg_data_t rd_mux;

  //////////////////////////////
  // write decode
  //////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      // unity gain, no offset, no loopback
      for (int i = 0; i < `RP_CHN; i++) begin
        adc_gain_o[i] <= gain_t'(`RP_GAIN_UNITY);
        adc_offs_o[i] <= '0;
        dac_gain_o[i] <= gain_t'(`RP_GAIN_UNITY);
        dac_offs_o[i] <= '0;
      end
      loop_o <= '0;
    end else if (cfg_we_i) begin
      for (int i = 0; i < `RP_CHN; i++) begin
        if (cfg_addr_i == cfg_addr_t'(`RP_A_ADC_MUL + i)) begin
          adc_gain_o[i] <= gain_t'(cfg_wdata_i);
        end
        // offsets keep only the low sample bits
        if (cfg_addr_i == cfg_addr_t'(`RP_A_ADC_SUM + i)) begin
          adc_offs_o[i] <= offs_t'(cfg_wdata_i[`RP_SMP_W-1:0]);
        end
        if (cfg_addr_i == cfg_addr_t'(`RP_A_DAC_MUL + i)) begin
          dac_gain_o[i] <= gain_t'(cfg_wdata_i);
        end
        if (cfg_addr_i == cfg_addr_t'(`RP_A_DAC_SUM + i)) begin
          dac_offs_o[i] <= offs_t'(cfg_wdata_i[`RP_SMP_W-1:0]);
        end
      end
      if (cfg_addr_i == cfg_addr_t'(`RP_A_LOOP)) begin
        loop_o <= cfg_wdata_i[`RP_CHN-1:0];
      end
    end
  end

  //////////////////////////////
  // readback
  //////////////////////////////

  // unmapped addresses fall through to zero
  always_comb begin
    rd_mux = '0;
    for (int i = 0; i < `RP_CHN; i++) begin
      if (cfg_addr_i == cfg_addr_t'(`RP_A_ADC_MUL + i)) begin
        rd_mux = cfg_data_t'(adc_gain_o[i]);
      end
      // offsets come back sign extended
      if (cfg_addr_i == cfg_addr_t'(`RP_A_ADC_SUM + i)) begin
        rd_mux = cfg_data_t'(adc_offs_o[i]);
      end
      if (cfg_addr_i == cfg_addr_t'(`RP_A_DAC_MUL + i)) begin
        rd_mux = cfg_data_t'(dac_gain_o[i]);
      end
      if (cfg_addr_i == cfg_addr_t'(`RP_A_DAC_SUM + i)) begin
        rd_mux = cfg_data_t'(dac_offs_o[i]);
      end
    end
    // mask in the low bits
    if (cfg_addr_i == cfg_addr_t'(`RP_A_LOOP)) begin
      rd_mux = cfg_data_t'(loop_o);
    end
  end

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      cfg_rdata_o <= '0;
    end else begin
      cfg_rdata_o <= rd_mux;
    end
  end

endmodule

`default_nettype wire

// ==== analog/adc_frontend.sv ====
// ADC front end
// input register with format conversion, digital loopback mux
// and one calibration stage per channel
`timescale 1ns/1ps
`default_nettype none

`include "rp_consts.svh"

module adc_frontend (
  input  logic                            adc_clk,
  input  logic                            top_rst,
  // ADC pins
  input  rp_pkg::adc_word_t [`RP_CHN-1:0] adc_dat_i,
  // calibrated DAC samples for loopback
  input  rp_pkg::smp_t      [`RP_CHN-1:0] dac_smp_i,
  input  rp_pkg::chn_mask_t               loop_i,
  // calibration
  input  rp_pkg::gain_t     [`RP_CHN-1:0] gain_i,
  input  rp_pkg::offs_t     [`RP_CHN-1:0] offs_i,
  // toward the oscilloscope
  output rp_pkg::smp_t      [`RP_CHN-1:0] osc_dat_o
);

  import rp_pkg::*;

  // the sample sits in the top bits of the pin word
  localparam int unsigned AW  = $bits(adc_word_t);
  localparam int unsigned LSB = AW - `RP_SMP_W;

  smp_t [`RP_CHN-1:0] adc_raw_q;
  smp_t [`RP_CHN-1:0] cal_in;

  //////////////////////////////
  // input register
  //////////////////////////////

  // offset binary with negative slope to two's complement
  // keep msb, invert the rest
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      adc_raw_q <= '0;
    end else begin
      for (int i = 0; i < `RP_CHN; i++) begin
        adc_raw_q[i] <= {adc_dat_i[i][AW-1], ~adc_dat_i[i][AW-2:LSB]};
      end
    end
  end

  //////////////////////////////
  // loopback and calibration
  //////////////////////////////

  for (genvar i = 0; i < `RP_CHN; i++) begin : g_chn

    // DAC sample replaces the ADC sample when looped back
    assign cal_in[i] = loop_i[i] ? dac_smp_i[i] : adc_raw_q[i];

    linear_calib i_linear_calib (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .smp_i   (cal_in[i]),
      .gain_i  (gain_i[i]),
      .offs_i  (offs_i[i]),
      .smp_o   (osc_dat_o[i])
    );

  end

endmodule

`default_nettype wire

// ==== analog/dac_backend.sv ====
// DAC back end
// per channel calibration of the generator samples,
// loopback tap and registered conversion to DAC code
`timescale 1ns/1ps
`default_nettype none

`include "rp_consts.svh"

module dac_backend (
  input  logic                            adc_clk,
  input  logic                            top_rst,
  // generator samples
  input  rp_pkg::smp_t      [`RP_CHN-1:0] gen_dat_i,
  // calibration
  input  rp_pkg::gain_t     [`RP_CHN-1:0] gain_i,
  input  rp_pkg::offs_t     [`RP_CHN-1:0] offs_i,
  // calibrated samples toward the loopback mux
  output rp_pkg::smp_t      [`RP_CHN-1:0] dac_smp_o,
  // DAC output codes
  output rp_pkg::dac_code_t [`RP_CHN-1:0] dac_code_o
);

  import rp_pkg::*;

  //////////////////////////////
  // calibration
  //////////////////////////////

  for (genvar i = 0; i < `RP_CHN; i++) begin : g_chn

    // 2 cycles, output also feeds the ADC loopback
    linear_calib i_linear_calib (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .smp_i   (gen_dat_i[i]),
      .gain_i  (gain_i[i]),
      .offs_i  (offs_i[i]),
      .smp_o   (dac_smp_o[i])
    );

  end

  //////////////////////////////
  // output code register
  //////////////////////////////

  // signed to offset binary with negative slope
  // msb kept, lower bits inverted
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dac_code_o <= '0;
    end else begin
      for (int i = 0; i < `RP_CHN; i++) begin
        dac_code_o[i] <= dac_code_t'({dac_smp_o[i][`RP_SMP_W-1],
                                      ~dac_smp_o[i][`RP_SMP_W-2:0]});
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rp_analog_top.sv ====
// analog signal path top level
// calibration register bank, ADC front end and DAC back end
// with digital loopback from the DAC side into the ADC side
`timescale 1ns/1ps
`default_nettype none

`include "rp_consts.svh"

module rp_analog_top (
  input  logic                            adc_clk,
  input  logic                            top_rst,
  // configuration port
  input  logic                            cfg_we_i,
  input  rp_pkg::cfg_addr_t               cfg_addr_i,
  input  rp_pkg::cfg_data_t               cfg_wdata_i,
  output rp_pkg::cfg_data_t               cfg_rdata_o,
  // ADC side
  input  rp_pkg::adc_word_t [`RP_CHN-1:0] adc_dat_i,
  output rp_pkg::smp_t      [`RP_CHN-1:0] osc_dat_o,
  // DAC side
  input  rp_pkg::smp_t      [`RP_CHN-1:0] gen_dat_i,
  output rp_pkg::dac_code_t [`RP_CHN-1:0] dac_code_o
);

  import rp_pkg::*;

  // calibration settings
  gain_t     [`RP_CHN-1:0] adc_gain;
  offs_t     [`RP_CHN-1:0] adc_offs;
  gain_t     [`RP_CHN-1:0] dac_gain;
  offs_t     [`RP_CHN-1:0] dac_offs;
  chn_mask_t               loop;

  // calibrated DAC samples for loopback
  smp_t      [`RP_CHN-1:0] dac_smp;

  //////////////////////////////
  // register bank
  //////////////////////////////

  calib_regs i_calib_regs (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .adc_gain_o  (adc_gain),
    .adc_offs_o  (adc_offs),
    .dac_gain_o  (dac_gain),
    .dac_offs_o  (dac_offs),
    .loop_o      (loop)
  );

  //////////////////////////////
  // analog paths
  //////////////////////////////

  // 3 cycles pins to osc, 4 from gen when looped back
  adc_frontend i_adc_frontend (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat_i),
    .dac_smp_i (dac_smp),
    .loop_i    (loop),
    .gain_i    (adc_gain),
    .offs_i    (adc_offs),
    .osc_dat_o (osc_dat_o)
  );

  // 3 cycles gen to code
  dac_backend i_dac_backend (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .gen_dat_i  (gen_dat_i),
    .gain_i     (dac_gain),
    .offs_i     (dac_offs),
    .dac_smp_o  (dac_smp),
    .dac_code_o (dac_code_o)
  );

endmodule

`default_nettype wire

// ==== tb/tb_rp_analog.sv ====
// testbench for the analog signal path top level
// table driven stimulus with a cycle exact reference model
// of the register bank, calibration, loopback and code conversion
`timescale 1ns/1ps
`default_nettype none

`include "rp_consts.svh"

module tb_rp_analog;

  import rp_pkg::*;

  localparam int MAX_ROWS  = 128;
  localparam int READY_TMO = 10;
  // result kinds per row
  localparam logic [2:0] CHK_OSC  = 3'b001;
  localparam logic [2:0] CHK_CODE = 3'b010;
  localparam logic [2:0] CHK_RD   = 3'b100;
  localparam logic [2:0] CHK_ALL  = 3'b111;
  // all bits below the msb flip between signed and pin or code format
  localparam logic [`RP_SMP_W-1:0] LOW_MASK = {1'b0, {(`RP_SMP_W-1){1'b1}}};

  // one step of stimulus
  typedef struct packed {
    logic                          we;
    cfg_addr_t                     addr;
    cfg_data_t                     wdata;
    adc_word_t [`RP_CHN-1:0]       adc;
    smp_t      [`RP_CHN-1:0]       gen;
    logic      [2:0]               chk;
  } row_t;

  logic                    adc_clk;
  logic                    top_rst;
  logic                    cfg_we;
  cfg_addr_t               cfg_addr;
  cfg_data_t               cfg_wdata;
  cfg_data_t               cfg_rdata;
  adc_word_t [`RP_CHN-1:0] adc_dat;
  smp_t      [`RP_CHN-1:0] gen_dat;
  smp_t      [`RP_CHN-1:0] osc_dat;
  dac_code_t [`RP_CHN-1:0] dac_code;

  row_t      tbl      [0:MAX_ROWS-1];
  int        n_rows;
  int        wait_cnt;
  int unsigned seed;

  // expected values indexed by the row that caused them
  cfg_data_t exp_rd   [0:MAX_ROWS-1];
  smp_t      dac_cal  [0:MAX_ROWS-1][0:`RP_CHN-1];
  dac_code_t exp_code [0:MAX_ROWS-1][0:`RP_CHN-1];
  smp_t      exp_osc  [0:MAX_ROWS-1][0:`RP_CHN-1];

  // model register state
  gain_t     m_adc_gain [0:`RP_CHN-1];
  offs_t     m_adc_offs [0:`RP_CHN-1];
  gain_t     m_dac_gain [0:`RP_CHN-1];
  offs_t     m_dac_offs [0:`RP_CHN-1];
  chn_mask_t m_loop;

  rp_analog_top i_rp_analog_top (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .cfg_we_i    (cfg_we),
    .cfg_addr_i  (cfg_addr),
    .cfg_wdata_i (cfg_wdata),
    .cfg_rdata_o (cfg_rdata),
    .adc_dat_i   (adc_dat),
    .gen_dat_i   (gen_dat),
    .osc_dat_o   (osc_dat),
    .dac_code_o  (dac_code)
  );

  initial begin
    adc_clk = 1'b0;
    forever #50 adc_clk = ~adc_clk;
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  // sample from pins 15:2 with all but the msb inverted
  function automatic smp_t fmt_adc(adc_word_t w);
    smp_t v;
    v = w[`RP_ADC_W-1:`RP_ADC_W-`RP_SMP_W];
    return smp_t'(v ^ LOW_MASK);
  endfunction

  // inverse of the pin format for directed samples
  function automatic adc_word_t adc_word_for(smp_t s, logic [1:0] lsb);
    return {s ^ LOW_MASK, lsb};
  endfunction

  // code keeps the msb and flips the rest
  function automatic dac_code_t to_code(smp_t s);
    return dac_code_t'(s ^ LOW_MASK);
  endfunction

  // gain then shift then offset then clamp in plain integers
  function automatic smp_t calib(smp_t s, gain_t g, offs_t o);
    longint p;
    p = longint'(s) * longint'(g);
    p = p >>> `RP_GAIN_FRAC;
    p = p + longint'(o);
    if (p > `RP_SMP_MAX) p = `RP_SMP_MAX;
    else if (p < `RP_SMP_MIN) p = `RP_SMP_MIN;
    return smp_t'(p);
  endfunction

  function automatic cfg_data_t read_model(cfg_addr_t a);
    int i;
    i = int'(a);
    if (i < 2) return cfg_data_t'(m_adc_gain[i]);
    if (i < 4) return {{2{m_adc_offs[i-2][`RP_SMP_W-1]}}, m_adc_offs[i-2]};
    if (i < 6) return cfg_data_t'(m_dac_gain[i-4]);
    if (i < 8) return {{2{m_dac_offs[i-6][`RP_SMP_W-1]}}, m_dac_offs[i-6]};
    if (i == 8) return {14'd0, m_loop};
    return '0;
  endfunction

  task automatic apply_write(input cfg_addr_t a, input cfg_data_t d);
    int i;
    i = int'(a);
    // offsets keep the low 14 bits
    // unmapped addresses are ignored
    if (i < 2) m_adc_gain[i] = gain_t'(d);
    else if (i < 4) m_adc_offs[i-2] = offs_t'(d[`RP_SMP_W-1:0]);
    else if (i < 6) m_dac_gain[i-4] = gain_t'(d);
    else if (i < 8) m_dac_offs[i-6] = offs_t'(d[`RP_SMP_W-1:0]);
    else if (i == 8) m_loop = d[`RP_CHN-1:0];
  endtask

  // expected results of row n in cycle order
  task automatic model_row(input int n);
    smp_t cal_in;
    // readback sees registers before this row's write
    exp_rd[n] = read_model(tbl[n].addr);
    // gen enters calibration before this row's write lands
    for (int c = 0; c < `RP_CHN; c++) begin
      dac_cal[n][c]  = calib(tbl[n].gen[c], m_dac_gain[c], m_dac_offs[c]);
      exp_code[n][c] = to_code(dac_cal[n][c]);
    end
    if (tbl[n].we) apply_write(tbl[n].addr, tbl[n].wdata);
    // adc sample sits one extra cycle in the input register
    for (int c = 0; c < `RP_CHN; c++) begin
      if (m_loop[c]) cal_in = (n > 0) ? dac_cal[n-1][c] : smp_t'(0);
      else cal_in = fmt_adc(tbl[n].adc[c]);
      exp_osc[n][c] = calib(cal_in, m_adc_gain[c], m_adc_offs[c]);
    end
  endtask

  //////////////////////////////
  // checks
  //////////////////////////////

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_smp(input string what, input smp_t got, input smp_t exp);
    if (got !== exp)
      fail_stop($sformatf("FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp));
  endtask

  task automatic check_code(input string what, input dac_code_t got, input dac_code_t exp);
    if (got !== exp)
      fail_stop($sformatf("FAILED at %0t: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic check_cfg(input string what, input cfg_data_t got, input cfg_data_t exp);
    if (got !== exp)
      fail_stop($sformatf("FAILED at %0t: %s got %h expected %h", $time, what, got, exp));
  endtask

  //////////////////////////////
  // stimulus table
  //////////////////////////////

  task automatic put_row(input row_t r);
    if (n_rows == MAX_ROWS) begin
      fail_stop("stimulus table is full");
    end else begin
      tbl[n_rows] = r;
      n_rows++;
    end
  endtask

  // optional write with random samples on both sides
  task automatic add_rnd(input logic we, input int addr, input int wdata, input logic [2:0] chk);
    row_t r;
    r       = '0;
    r.we    = we;
    r.addr  = cfg_addr_t'(addr);
    r.wdata = cfg_data_t'(wdata);
    r.chk   = chk;
    for (int c = 0; c < `RP_CHN; c++) begin
      r.adc[c] = adc_word_t'($urandom);
      r.gen[c] = smp_t'($urandom);
    end
    put_row(r);
  endtask

  // directed samples without a write
  task automatic add_fix(input int a0, input int a1, input int g0, input int g1);
    row_t r;
    r        = '0;
    r.adc[0] = adc_word_for(smp_t'(a0), 2'($urandom));
    r.adc[1] = adc_word_for(smp_t'(a1), 2'($urandom));
    r.gen[0] = smp_t'(g0);
    r.gen[1] = smp_t'(g1);
    r.chk    = CHK_ALL;
    put_row(r);
  endtask

  task automatic build_table();
    n_rows = 0;
    // reset values at every address
    // 9 and 15 are unmapped
    for (int a = 0; a < 10; a++) add_rnd(1'b0, a, 0, CHK_ALL);
    add_rnd(1'b0, 15, 0, CHK_ALL);
    // unity calibration
    repeat (6) add_rnd(1'b0, 0, 0, CHK_OSC | CHK_CODE);
    // ADC gains and offsets
    add_rnd(1'b1, `RP_A_ADC_MUL, 20000, CHK_ALL);
    add_rnd(1'b1, `RP_A_ADC_MUL + 1, -12000, CHK_ALL);
    add_rnd(1'b1, `RP_A_ADC_SUM, 300, CHK_ALL);
    add_rnd(1'b1, `RP_A_ADC_SUM + 1, -500, CHK_ALL);
    repeat (5) add_rnd(1'b0, `RP_A_ADC_SUM + 1, 0, CHK_ALL);
    // near 2.0 gain drives both clamps
    add_rnd(1'b1, `RP_A_ADC_MUL, 32767, CHK_ALL);
    add_rnd(1'b1, `RP_A_ADC_MUL + 1, 32767, CHK_ALL);
    add_fix(8000, -8000, 0, 0);
    add_fix(-8192, 8191, 0, 0);
    add_fix(4000, -4200, 0, 0);
    // DAC side with upper offset bits dropped on write
    add_rnd(1'b1, `RP_A_DAC_MUL, 24000, CHK_ALL);
    add_rnd(1'b1, `RP_A_DAC_MUL + 1, 10000, CHK_ALL);
    add_rnd(1'b1, `RP_A_DAC_SUM, 1000, CHK_ALL);
    add_rnd(1'b1, `RP_A_DAC_SUM + 1, 'h7f00, CHK_ALL);
    repeat (5) add_rnd(1'b0, `RP_A_DAC_SUM + 1, 0, CHK_ALL);
    add_fix(0, 0, 8191, -8192);
    add_fix(0, 0, -8192, 8191);
    // loopback on one channel then the other then off
    add_rnd(1'b1, `RP_A_LOOP, 1, CHK_ALL);
    repeat (6) add_rnd(1'b0, `RP_A_LOOP, 0, CHK_ALL);
    add_rnd(1'b1, `RP_A_LOOP, 2, CHK_ALL);
    repeat (5) add_rnd(1'b0, `RP_A_LOOP, 0, CHK_ALL);
    add_rnd(1'b1, `RP_A_LOOP, 'hfffc, CHK_ALL);
    repeat (4) add_rnd(1'b0, 0, 0, CHK_ALL);
    // unmapped writes must not disturb anything
    add_rnd(1'b1, 9, 'hffff, CHK_ALL);
    add_rnd(1'b1, 12, 'h1234, CHK_ALL);
    add_rnd(1'b1, 15, 'habcd, CHK_ALL);
    for (int a = 0; a < 16; a++) add_rnd(1'b0, a, 0, CHK_ALL);
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    seed      = 32'hf556483f;
    void'($urandom(seed));
    top_rst   = 1'b1;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    adc_dat   = '0;
    gen_dat   = '0;
    m_loop    = '0;
    for (int c = 0; c < `RP_CHN; c++) begin
      m_adc_gain[c] = gain_t'(`RP_GAIN_UNITY);
      m_adc_offs[c] = '0;
      m_dac_gain[c] = gain_t'(`RP_GAIN_UNITY);
      m_dac_offs[c] = '0;
    end
    build_table();

    repeat (2) @(posedge adc_clk);
    top_rst <= 1'b0;

    // bank shows unity gain at address 0 once out of reset
    wait_cnt = 0;
    @(negedge adc_clk);
    while (cfg_rdata !== cfg_data_t'(`RP_GAIN_UNITY)) begin
      if (wait_cnt == READY_TMO) begin
        fail_stop("timeout: register bank did not leave reset");
      end else begin
        @(negedge adc_clk);
        wait_cnt++;
      end
    end

    // drive on the rising edge and check on the falling edge
    for (int k = 0; k < n_rows + 3; k++) begin
      @(posedge adc_clk);
      if (k < n_rows) begin
        cfg_we    <= tbl[k].we;
        cfg_addr  <= tbl[k].addr;
        cfg_wdata <= tbl[k].wdata;
        adc_dat   <= tbl[k].adc;
        gen_dat   <= tbl[k].gen;
        model_row(k);
      end else begin
        cfg_we <= 1'b0;
      end
      @(negedge adc_clk);
      // readback lags one cycle and the sample paths three
      if (k >= 1 && k - 1 < n_rows && (tbl[k-1].chk & CHK_RD) != 0)
        check_cfg($sformatf("row %0d readback", k - 1), cfg_rdata, exp_rd[k-1]);
      if (k >= 3) begin
        for (int c = 0; c < `RP_CHN; c++) begin
          if ((tbl[k-3].chk & CHK_OSC) != 0)
            check_smp($sformatf("row %0d osc ch%0d", k - 3, c), osc_dat[c], exp_osc[k-3][c]);
          if ((tbl[k-3].chk & CHK_CODE) != 0)
            check_code($sformatf("row %0d dac ch%0d", k - 3, c), dac_code[c],
                       exp_code[k-3][c]);
        end
      end
    end

    // any mismatch has already stopped the run
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+common
common/rp_pkg.sv
hdl/linear_calib.sv
hdl/calib_regs.sv
analog/adc_frontend.sv
analog/dac_backend.sv
hdl/rp_analog_top.sv
tb/tb_rp_analog.sv
